/* Bender.yml */
package:
  name: pipeCore

sources:
  - rtl/corePkg.sv
  - rtl/fetchStage.sv
  - rtl/instDecoder.sv
  - rtl/regFile.sv
  - rtl/operandBypass.sv
  - rtl/decodeStage.sv
  - rtl/executeStage.sv
  - rtl/writebackStage.sv
  - rtl/pipeCore.sv
  - target: test
    files:
      - bench/memResponder.sv
      - bench/pipeCoreTb.sv

/* bench/memResponder.sv */
`timescale 1ns/1ps
`default_nettype none

module memResponder
    import corePkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic instReq,
    input  wordT instAddr,
    output logic instValid,
    output wordT instData,
    input  logic dataRead,
    input  logic dataWrite,
    input  wordT dataAddr,
    input  wordT dataWdata,
    output logic dataValid,
    output wordT dataRdata
);

    localparam int instWords = 512;
    localparam int dataWords = 256;

    wordT   instMem [instWords];   // Loaded by the testbench
    wordT   dataMem [dataWords];
    integer instSeed = 32'hb8c7_c9e7;   // One stream per port
    integer dataSeed = 32'hb8c7_c9e7;

    // Instruction port, one request at a time
    initial begin
        instValid = 1'b0;
        instData  = '0;
        forever begin
            @(posedge clk);
            #2;
            if (!reset && instReq) begin
                repeat (1 + $unsigned($random(instSeed)) % 3) @(posedge clk);
                #2;
                instValid = 1'b1;
                instData  = (instAddr[31:2] < instWords) ? instMem[instAddr[10:2]] : '0;
                @(posedge clk);
                #2;
                instValid = 1'b0;
            end
        end
    end

    initial begin
        dataValid = 1'b0;
        dataRdata = '0;
        forever begin
            @(posedge clk);
            #2;
            if (!reset && (dataRead || dataWrite)) begin
                repeat (1 + $unsigned($random(dataSeed)) % 3) @(posedge clk);
                #2;
                if (dataWrite)
                    dataMem[dataAddr[9:2]] = dataWdata;
                dataRdata = dataMem[dataAddr[9:2]];
                dataValid = 1'b1;
                @(posedge clk);
                #2;
                dataValid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/pipeCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCoreTb
    import corePkg::*;
();

    localparam int progWords    = 512;
    localparam int dataWords    = 256;
    localparam int numInit      = 8;
    localparam int retireTarget = 400;
    localparam int modelSteps   = 440;
    localparam int cycleLimit   = retireTarget * 12;

    typedef struct packed {
        wordT    pc;
        logic    we;
        regAddrT regNum;
        wordT    data;
    } retireRecT;

    typedef struct packed {
        wordT addr;
        wordT data;
    } storeRecT;

    logic    clk;
    logic    reset;
    logic    instReq;
    wordT    instAddr;
    logic    instValid;
    wordT    instData;
    logic    dataRead;
    logic    dataWrite;
    wordT    dataAddr;
    wordT    dataWdata;
    logic    dataValid;
    wordT    dataRdata;
    logic    retireValid;
    wordT    retirePc;
    logic    retireWe;
    regAddrT retireReg;
    wordT    retireData;

    integer    seed;
    wordT      progMem [progWords];
    wordT      modelRegs [numRegs];
    wordT      modelMem [dataWords];
    retireRecT expRetire [$];
    storeRecT  expStore [$];
    int        resetErrs = 0;
    int        orderErrs = 0;
    int        valueErrs = 0;
    int        storeErrs = 0;
    int        loadUseCount = 0;
    int        retired = 0;
    int        stores = 0;
    int        cycles = 0;
    int        totalErrs;
    logic      sawReq = 1'b0;
    logic      sawInst = 1'b0;

    pipeCore dut_i (.*);

    memResponder mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic wordT fillWord(wordT addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic regAddrT pickReg();
        int r;
        r = $unsigned($random(seed)) % 9;
        return (r == 8) ? 5'd31 : regAddrT'(r);   // Small set for more hazards
    endfunction

    function automatic wordT encR(regAddrT rs, regAddrT rt, regAddrT rd, logic [5:0] fn);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT encI(logic [5:0] op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic genProgram();
        logic [5:0] fns [7] = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt, fnSltu};
        logic [5:0] immOps [5] = '{opAddiu, opAndi, opOri, opXori, opLui};
        int         kind;
        int         off;
        logic       delaySlot;
        wordT       target;
        regAddrT    rs;
        delaySlot = 1'b0;
        for (int i = 0; i < progWords; i++) begin
            if (i < numInit) begin
                progMem[i] = encI(opAddiu, 5'd0, (i == 0) ? 5'd31 : regAddrT'(i),
                                  16'($random(seed)));
                continue;
            end
            kind = $unsigned($random(seed)) % 16;
            if (delaySlot && kind >= 13)
                kind = kind - 13;   // No control flow in a delay slot
            off    = 1 + $unsigned($random(seed)) % 6;
            target = (i + 1 + off) * 4;
            rs     = pickReg();
            case (kind)
                0, 1, 2, 3, 4, 5:
                    progMem[i] = encR(rs, pickReg(), pickReg(), fns[$unsigned($random(seed)) % 7]);
                6, 7, 8:
                    progMem[i] = encI(immOps[$unsigned($random(seed)) % 5], rs, pickReg(),
                                      16'($random(seed)));
                9, 10:
                    progMem[i] = encI(opLw, 5'd0, pickReg(), {6'd0, 8'($random(seed)), 2'b00});
                11, 12:
                    progMem[i] = encI(opSw, 5'd0, rs, {6'd0, 8'($random(seed)), 2'b00});
                13:
                    progMem[i] = encI($random(seed) & 1 ? opBeq : opBne, rs,
                                      $random(seed) & 1 ? rs : pickReg(), 16'(off));
                default:
                    progMem[i] = {(kind == 14) ? opJ : opJal, target[27:2]};
            endcase
            delaySlot = (kind >= 13);
        end
    endtask

    // Architectural model with one delay slot
    task automatic runModel();
        wordT       pc;
        wordT       npc;
        wordT       target;
        wordT       inst;
        wordT       val;
        wordT       addr;
        wordT       sext;
        wordT       zext;
        wordT       a;
        wordT       b;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    dst;
        regAddrT    lastLoad;
        logic [5:0] op;
        logic       taken;
        pc       = resetVector;
        npc      = pc + 4;
        lastLoad = '0;
        for (int i = 0; i < numRegs; i++)
            modelRegs[i] = '0;
        for (int i = 0; i < dataWords; i++)
            modelMem[i] = fillWord(i * 4);
        for (int step = 0; step < modelSteps; step++) begin
            inst   = (pc[31:2] < progWords) ? progMem[pc[10:2]] : '0;
            op     = inst[31:26];
            rs     = inst[25:21];
            rt     = inst[20:16];
            sext   = {{16{inst[15]}}, inst[15:0]};
            zext   = {16'h0000, inst[15:0]};
            a      = modelRegs[rs];
            b      = modelRegs[rt];
            dst    = '0;
            val    = '0;
            taken  = 1'b0;
            target = '0;
            if (lastLoad != 0 && (rs == lastLoad || rt == lastLoad))
                loadUseCount++;
            case (op)
                opSpecial: begin
                    dst = inst[15:11];
                    case (inst[5:0])
                        fnAddu:  val = a + b;
                        fnSubu:  val = a - b;
                        fnAnd:   val = a & b;
                        fnOr:    val = a | b;
                        fnXor:   val = a ^ b;
                        fnSlt:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fnSltu:  val = (a < b) ? 32'd1 : 32'd0;
                        default: dst = '0;
                    endcase
                end
                opAddiu: begin
                    dst = rt;
                    val = a + sext;
                end
                opAndi: begin
                    dst = rt;
                    val = a & zext;
                end
                opOri: begin
                    dst = rt;
                    val = a | zext;
                end
                opXori: begin
                    dst = rt;
                    val = a ^ zext;
                end
                opLui: begin
                    dst = rt;
                    val = {inst[15:0], 16'h0000};
                end
                opLw: begin
                    dst  = rt;
                    addr = a + sext;
                    val  = modelMem[addr[9:2]];
                end
                opSw: begin
                    addr = a + sext;
                    expStore.push_back('{addr, b});
                    modelMem[addr[9:2]] = b;
                end
                opBeq, opBne: begin
                    taken  = (op == opBeq) ? (a == b) : (a != b);
                    target = pc + 4 + {sext[29:0], 2'b00};
                end
                opJ, opJal: begin
                    taken  = 1'b1;
                    target = pc + 4;
                    target = {target[31:28], inst[25:0], 2'b00};
                    if (op == opJal) begin
                        dst = 5'd31;
                        val = pc + 8;
                    end
                end
                default: ;
            endcase
            if (dst == 0)
                val = '0;
            else
                modelRegs[dst] = val;
            expRetire.push_back('{pc, dst != 0, dst, val});
            lastLoad = (op == opLw) ? dst : '0;
            pc  = npc;
            npc = taken ? target : npc + 4;
        end
    endtask

    task automatic checkFetchAddr(wordT addr);
        if (addr !== resetVector) begin
            $display("FAILED %0t: first instAddr %h, expected %h", $time, addr, resetVector);
            resetErrs++;
        end
    endtask

    task automatic checkRetire(wordT pc, logic we, regAddrT regNum, wordT data);
        retireRecT exp;
        if (expRetire.size() == 0) begin
            $display("Retirement at %0t with no instruction left in the model", $time);
            orderErrs++;
            return;
        end
        exp = expRetire.pop_front();
        if (pc !== exp.pc) begin
            $display("FAILED %0t: retirePc %h, expected %h", $time, pc, exp.pc);
            orderErrs++;
        end else if (we !== exp.we || regNum !== exp.regNum || (exp.we && data !== exp.data)) begin
            $display("FAILED %0t: pc %h wrote %b r%0d=%h, expected %b r%0d=%h", $time, pc,
                     we, regNum, data, exp.we, exp.regNum, exp.data);
            valueErrs++;
        end
    endtask

    task automatic checkStore(wordT addr, wordT data);
        storeRecT exp;
        if (expStore.size() == 0) begin
            $display("Store at %0t that the model never made", $time);
            storeErrs++;
            return;
        end
        exp = expStore.pop_front();
        if (addr !== exp.addr || data !== exp.data) begin
            $display("FAILED %0t: store %h to %h, expected %h to %h", $time, data, addr,
                     exp.data, exp.addr);
            storeErrs++;
        end
    endtask

    initial begin
        seed  = 32'hb8c7_c9e7;
        reset = 1'b1;
        genProgram();
        runModel();
        for (int i = 0; i < progWords; i++)
            mem_i.instMem[i] = progMem[i];
        for (int i = 0; i < dataWords; i++)
            mem_i.dataMem[i] = fillWord(i * 4);
        @(posedge clk);
        @(negedge clk);
        if (instReq || dataRead || dataWrite || retireValid) begin
            $display("Port active while reset is asserted");
            resetErrs++;
        end
        @(posedge clk);
        #2 reset = 1'b0;
        while (retired < retireTarget && cycles < cycleLimit) begin
            @(negedge clk);
            cycles++;
            if (!sawReq && instReq) begin
                checkFetchAddr(instAddr);
                sawReq = 1'b1;
            end
            if (!sawInst && (retireValid || dataWrite)) begin
                $display("Retirement or store before the first instruction was fetched");
                resetErrs++;
            end
            if (!sawInst && instValid) begin
                sawInst = 1'b1;
                $display("Reset and first fetch: %s", (resetErrs == 0) ? "ok" : "wrong");
            end
            if (dataWrite && dataValid) begin
                checkStore(dataAddr, dataWdata);
                stores++;
            end
            if (retireValid) begin
                checkRetire(retirePc, retireWe, retireReg, retireData);
                retired++;
            end
        end
        totalErrs = resetErrs + orderErrs + valueErrs + storeErrs;
        if (retired < retireTarget) begin
            $display("Timeout: only %0d of %0d instructions retired in %0d cycles",
                     retired, retireTarget, cycleLimit);
            totalErrs++;
        end
        $display("Retirement order: %0d mismatches", orderErrs);
        $display("Register writes: %0d mismatches", valueErrs);
        $display("Forwarding and load-use: %0d load-use pairs covered", loadUseCount);
        $display("Stores: %0d checked, %0d mismatches", stores, storeErrs);
        $display("Deadlock: %0d retirements in %0d cycles", retired, cycles);
        $display("Checked %0d retirements and %0d stores, %0d errors", retired, stores, totalErrs);
        if (totalErrs == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* pipeCore.f */
rtl/corePkg.sv
rtl/fetchStage.sv
rtl/instDecoder.sv
rtl/regFile.sv
rtl/operandBypass.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/writebackStage.sv
rtl/pipeCore.sv
bench/memResponder.sv
bench/pipeCoreTb.sv

/* rtl/corePkg.sv */
`default_nettype none

package corePkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    localparam wordT    resetVector = 32'h0000_0000;
    localparam wordT    instBytes   = 32'd4;
    localparam int      numRegs     = 32;
    localparam regAddrT linkReg     = 5'd31;

    // Field lsb positions
    localparam int opcodeLsb  = 26;
    localparam int rsLsb      = 21;
    localparam int rtLsb      = 16;
    localparam int rdLsb      = 11;
    localparam int functLsb   = 0;
    localparam int immLsb     = 0;
    localparam int immWidth   = 16;
    localparam int indexLsb   = 0;
    localparam int indexWidth = 26;

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // SPECIAL function codes
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSlt, aluSltu, aluLui, aluPass
    } aluOpT;

    typedef enum logic [1:0] {wbNone, wbAlu, wbLink, wbMem} wbSrcT;

    typedef enum logic [1:0] {brNone, brBeq, brBne, brJump} branchT;

    typedef struct packed {
        regAddrT readReg1;
        regAddrT readReg2;
        regAddrT dest;
        wordT    imm;
        logic    useImm;   // Immediate is ALU operand B
        aluOpT   aluOp;
        branchT  branch;
        logic    link;
        logic    memLoad;
        logic    memStore;
        wbSrcT   wbSrc;
    } ctrlT;

    localparam ctrlT nopCtrl = '{aluOp: aluPass, branch: brNone, wbSrc: wbNone, default: '0};

    typedef struct packed {
        wordT pc;
        wordT inst;
    } fetchPacketT;

    typedef struct packed {
        wordT pc;
        ctrlT ctrl;
        wordT aluResult;   // Also carries the JAL link
        wordT memAddr;
        wordT storeData;
    } execPacketT;

    typedef struct packed {
        wordT    pc;
        regAddrT dest;
        wbSrcT   wbSrc;
        wordT    result;
    } wbPacketT;

    typedef struct packed {
        logic    valid;
        regAddrT regNum;
        wordT    value;
    } fwdT;

endpackage

`default_nettype wire

/* rtl/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import corePkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        fetchValid,
    input  fetchPacketT fetchPacket,
    output logic        fetchTake,
    output logic        redirect,
    output wordT        redirectPc,
    input  fwdT         fwdExec,
    input  fwdT         fwdWb,
    input  logic        execStall,
    output logic        execValid,
    output execPacketT  execPacket,
    output regAddrT     readReg1,
    output regAddrT     readReg2,
    input  wordT        readData1,
    input  wordT        readData2
);

    logic        dValid;
    fetchPacketT dPacket;
    ctrlT        ctrl;
    wordT        val1;
    wordT        val2;
    logic        notReady1;
    logic        notReady2;
    logic        stall;
    wordT        pcPlus4;
    wordT        opB;
    wordT        aluOut;
    logic        taken;

    instDecoder decoder_i (
        .inst (dPacket.inst),
        .ctrl (ctrl)
    );

    assign readReg1 = ctrl.readReg1;
    assign readReg2 = ctrl.readReg2;

    operandBypass bypass1_i (
        .request  (ctrl.readReg1),
        .original (readData1),
        .fwdExec  (fwdExec),
        .fwdWb    (fwdWb),
        .value    (val1),
        .notReady (notReady1)
    );

    operandBypass bypass2_i (
        .request  (ctrl.readReg2),
        .original (readData2),
        .fwdExec  (fwdExec),
        .fwdWb    (fwdWb),
        .value    (val2),
        .notReady (notReady2)
    );

    assign stall     = execStall || (dValid && (notReady1 || notReady2));
    assign fetchTake = fetchValid && !stall;

    always_ff @(posedge clk) begin
        if (reset)
            dValid <= 1'b0;
        else if (!stall)
            dValid <= fetchValid;
    end

    always_ff @(posedge clk) begin
        if (!stall)
            dPacket <= fetchPacket;
    end

    assign pcPlus4 = dPacket.pc + instBytes;
    assign opB     = ctrl.useImm ? ctrl.imm : val2;

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluOut = val1 + opB;
            aluSub:  aluOut = val1 - opB;
            aluAnd:  aluOut = val1 & opB;
            aluOr:   aluOut = val1 | opB;
            aluXor:  aluOut = val1 ^ opB;
            aluSlt:  aluOut = {31'b0, $signed(val1) < $signed(opB)};
            aluSltu: aluOut = {31'b0, val1 < opB};
            aluLui:  aluOut = {opB[15:0], 16'h0000};
            default: aluOut = opB;
        endcase
    end

    always_comb begin
        case (ctrl.branch)
            brBeq:   taken = (val1 == val2);
            brBne:   taken = (val1 != val2);
            brJump:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // No redirect while stalled
    assign redirect   = dValid && !stall && taken;
    assign redirectPc = (ctrl.branch == brJump)
        ? {pcPlus4[31:indexWidth + 2], ctrl.imm[indexWidth - 1:0], 2'b00}
        : pcPlus4 + {ctrl.imm[29:0], 2'b00};

    assign execValid  = dValid && !stall;
    assign execPacket = '{
        pc:        dPacket.pc,
        ctrl:      ctrl,
        aluResult: ctrl.link ? pcPlus4 + instBytes : aluOut,
        memAddr:   val1 + ctrl.imm,
        storeData: val2
    };

endmodule

`default_nettype wire

/* rtl/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage
    import corePkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       execValid,
    input  execPacketT execPacket,
    output logic       execStall,
    output fwdT        fwdExec,
    output logic       dataRead,
    output logic       dataWrite,
    output wordT       dataAddr,
    output wordT       dataWdata,
    input  logic       dataValid,
    input  wordT       dataRdata,
    output logic       wbValid,
    output wbPacketT   wbPacket
);

    logic       eValid;
    execPacketT ePacket;
    wbSrcT      wbSrc;

    always_ff @(posedge clk) begin
        if (reset)
            eValid <= 1'b0;
        else if (!execStall)
            eValid <= execValid;
    end

    always_ff @(posedge clk) begin
        if (!execStall)
            ePacket <= execPacket;
    end

    assign wbSrc = ePacket.ctrl.wbSrc;

    // Request held until the data strobe
    assign dataRead  = eValid && ePacket.ctrl.memLoad;
    assign dataWrite = eValid && ePacket.ctrl.memStore;
    assign dataAddr  = ePacket.memAddr;
    assign dataWdata = ePacket.storeData;
    assign execStall = (dataRead || dataWrite) && !dataValid;

    // Load result does not exist yet
    assign fwdExec = '{
        valid:  eValid && (wbSrc == wbAlu || wbSrc == wbLink),
        regNum: eValid ? ePacket.ctrl.dest : '0,
        value:  ePacket.aluResult
    };

    assign wbValid  = eValid && !execStall;
    assign wbPacket = '{
        pc:     ePacket.pc,
        dest:   ePacket.ctrl.dest,
        wbSrc:  wbSrc,
        result: (wbSrc == wbMem) ? dataRdata : ePacket.aluResult
    };

endmodule

`default_nettype wire

/* rtl/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage
    import corePkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output logic        instReq,
    output wordT        instAddr,
    input  logic        instValid,
    input  wordT        instData,
    input  logic        redirect,
    input  wordT        redirectPc,
    input  logic        fetchTake,
    output logic        fetchValid,
    output fetchPacketT fetchPacket
);

    wordT        pc;
    wordT        nextPc;
    logic        bufValid;
    fetchPacketT buffer;
    logic        pendValid;   // Branch target waiting for the delay slot
    wordT        pendPc;

    assign instAddr    = pc;
    assign fetchValid  = bufValid;
    assign fetchPacket = buffer;

    // Address after the one in flight
    always_comb begin
        if (redirect)
            nextPc = redirectPc;
        else if (pendValid)
            nextPc = pendPc;
        else
            nextPc = pc + instBytes;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instReq   <= 1'b0;
            pc        <= resetVector;
            bufValid  <= 1'b0;
            pendValid <= 1'b0;
        end else if (instReq && instValid) begin
            instReq   <= 1'b0;
            bufValid  <= 1'b1;
            buffer    <= '{pc: pc, inst: instData};
            pc        <= nextPc;
            pendValid <= 1'b0;
        end else begin
            if (fetchTake)
                bufValid <= 1'b0;
            if (!instReq && (!bufValid || fetchTake))
                instReq <= 1'b1;
            if (redirect && instReq) begin   // Delay slot still in flight
                pendValid <= 1'b1;
                pendPc    <= redirectPc;
            end else if (redirect) begin
                pc <= redirectPc;   // Delay slot already buffered
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/instDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instDecoder
    import corePkg::*;
(
    input  wordT inst,
    output ctrlT ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddrT    rs;
    regAddrT    rt;
    regAddrT    rd;
    wordT       immSext;
    wordT       immZext;
    wordT       jumpIndex;

    assign opcode    = inst[opcodeLsb +: 6];
    assign funct     = inst[functLsb +: 6];
    assign rs        = inst[rsLsb +: 5];
    assign rt        = inst[rtLsb +: 5];
    assign rd        = inst[rdLsb +: 5];
    assign immSext   = {{(32 - immWidth){inst[immLsb + immWidth - 1]}}, inst[immLsb +: immWidth]};
    assign immZext   = {{(32 - immWidth){1'b0}}, inst[immLsb +: immWidth]};
    assign jumpIndex = {{(32 - indexWidth){1'b0}}, inst[indexLsb +: indexWidth]};

    always_comb begin
        ctrl = nopCtrl;
        case (opcode)
            opSpecial: begin
                ctrl.readReg1 = rs;
                ctrl.readReg2 = rt;
                ctrl.dest     = rd;
                ctrl.wbSrc    = wbAlu;
                case (funct)
                    fnAddu:  ctrl.aluOp = aluAdd;
                    fnSubu:  ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnXor:   ctrl.aluOp = aluXor;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    fnSltu:  ctrl.aluOp = aluSltu;
                    default: ctrl = nopCtrl;
                endcase
            end
            opAddiu, opAndi, opOri, opXori, opLui: begin
                ctrl.readReg1 = (opcode == opLui) ? '0 : rs;
                ctrl.dest     = rt;
                ctrl.imm      = (opcode == opAddiu) ? immSext : immZext;
                ctrl.useImm   = 1'b1;
                ctrl.wbSrc    = wbAlu;
                case (opcode)
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    opLui:   ctrl.aluOp = aluLui;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            opLw: begin
                ctrl.readReg1 = rs;
                ctrl.dest     = rt;
                ctrl.imm      = immSext;
                ctrl.useImm   = 1'b1;
                ctrl.memLoad  = 1'b1;
                ctrl.wbSrc    = wbMem;
            end
            opSw: begin
                ctrl.readReg1 = rs;
                ctrl.readReg2 = rt;
                ctrl.imm      = immSext;
                ctrl.useImm   = 1'b1;
                ctrl.memStore = 1'b1;
            end
            opBeq, opBne: begin
                ctrl.readReg1 = rs;
                ctrl.readReg2 = rt;
                ctrl.imm      = immSext;
                ctrl.branch   = (opcode == opBeq) ? brBeq : brBne;
            end
            opJ, opJal: begin
                ctrl.imm    = jumpIndex;
                ctrl.branch = brJump;
                if (opcode == opJal) begin
                    ctrl.link  = 1'b1;
                    ctrl.dest  = linkReg;
                    ctrl.wbSrc = wbLink;
                end
            end
            default: ctrl = nopCtrl;   // Outside the subset
        endcase
    end

endmodule

`default_nettype wire

/* rtl/operandBypass.sv */
`timescale 1ns/1ps
`default_nettype none

module operandBypass
    import corePkg::*;
(
    input  regAddrT request,
    input  wordT    original,
    input  fwdT     fwdExec,
    input  fwdT     fwdWb,
    output wordT    value,
    output logic    notReady
);

    // Youngest producer wins
    always_comb begin
        value    = original;
        notReady = 1'b0;
        if (request != '0) begin
            if (fwdExec.regNum == request) begin
                value    = fwdExec.value;
                notReady = !fwdExec.valid;   // Load still in flight
            end else if (fwdWb.regNum == request) begin
                value    = fwdWb.value;
                notReady = !fwdWb.valid;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/pipeCore.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCore
    import corePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    output logic    instReq,
    output wordT    instAddr,
    input  logic    instValid,
    input  wordT    instData,
    output logic    dataRead,
    output logic    dataWrite,
    output wordT    dataAddr,
    output wordT    dataWdata,
    input  logic    dataValid,
    input  wordT    dataRdata,
    output logic    retireValid,
    output wordT    retirePc,
    output logic    retireWe,
    output regAddrT retireReg,
    output wordT    retireData
);

    // Fetch to decode
    logic        fetchValid;
    logic        fetchTake;
    fetchPacketT fetchPacket;
    logic        redirect;
    wordT        redirectPc;

    // Decode to execute
    logic        execValid;
    logic        execStall;
    execPacketT  execPacket;

    logic        wbValid;
    wbPacketT    wbPacket;
    fwdT         fwdExec;
    fwdT         fwdWb;

    // Register file
    regAddrT     readReg1;
    regAddrT     readReg2;
    wordT        readData1;
    wordT        readData2;
    regAddrT     writeReg;
    wordT        writeData;

    fetchStage fetch_i (.*);

    decodeStage decode_i (.*);

    regFile regFile_i (.*);

    executeStage execute_i (.*);

    writebackStage writeback_i (.*);

endmodule

`default_nettype wire

/* rtl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile
    import corePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  regAddrT readReg1,
    input  regAddrT readReg2,
    output wordT    readData1,
    output wordT    readData2,
    input  regAddrT writeReg,
    input  wordT    writeData
);

    wordT regs [numRegs];

    function automatic wordT readPort(regAddrT addr);
        if (addr == '0)
            return '0;
        if (addr == writeReg)
            return writeData;   // Write-through
        return regs[addr];
    endfunction

    always_comb begin
        readData1 = readPort(readReg1);
        readData2 = readPort(readReg2);
    end

    always_ff @(posedge clk) begin
        if (!reset && writeReg != '0)
            regs[writeReg] <= writeData;
    end

endmodule

`default_nettype wire

/* rtl/writebackStage.sv */
`timescale 1ns/1ps
`default_nettype none

module writebackStage
    import corePkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     wbValid,
    input  wbPacketT wbPacket,
    output regAddrT  writeReg,
    output wordT     writeData,
    output fwdT      fwdWb,
    output logic     retireValid,
    output wordT     retirePc,
    output logic     retireWe,
    output regAddrT  retireReg,
    output wordT     retireData
);

    logic     wValid;
    wbPacketT wPacket;
    logic     writes;

    always_ff @(posedge clk) begin
        if (reset)
            wValid <= 1'b0;
        else
            wValid <= wbValid;
    end

    always_ff @(posedge clk) begin
        wPacket <= wbPacket;
    end

    assign writes    = wValid && wPacket.wbSrc != wbNone;
    assign writeReg  = writes ? wPacket.dest : '0;   // r0 when nothing is written
    assign writeData = wPacket.result;

    assign fwdWb = '{valid: writes, regNum: writeReg, value: writeData};

    assign retireValid = wValid;
    assign retirePc    = wPacket.pc;
    assign retireWe    = writeReg != '0;
    assign retireReg   = writeReg;
    assign retireData  = writeData;

endmodule

`default_nettype wire
